// File: riscboy_core.f
hdl/riscboy_pkg.sv
hdl/wb_arbiter.sv
hdl/wb_decoder.sv
hdl/sram_ctrl.sv
hdl/gpio.sv
hdl/pwm_tiny.sv
hdl/line_fetch.sv
hdl/riscboy_core.sv
sim/tb_riscboy_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscboy_core
FILELIST  ?= riscboy_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_riscboy_core.sv
// ==========================================================================
// Testbench for riscboy_core at its default parameters. Memory words are
// checked against a local model, so only words written first are read back
// ==========================================================================

module tb_riscboy_core import riscboy_pkg::*; ();

localparam int MEM_WORDS  = 1024;
localparam int N_PADS     = 11;
localparam int LINE_WORDS = 64;
localparam int TIMEOUT    = 2000;

localparam logic [1:0] OP_WR     = 2'd0;
localparam logic [1:0] OP_RD     = 2'd1;
localparam logic [1:0] OP_RD_MEM = 2'd2;

localparam logic [1:0] TAG_MEM  = 2'd0;
localparam logic [1:0] TAG_GPIO = 2'd1;
localparam logic [1:0] TAG_PWM  = 2'd2;
localparam logic [1:0] TAG_NONE = 2'd3;

localparam logic [W_ADDR-1:0] FETCH_BASE = 16'h0400;

typedef struct packed {
	logic [1:0]        tag;
	logic [1:0]        op;
	logic [W_ADDR-1:0] addr;
	logic [W_DATA-1:0] data;
	logic [W_SEL-1:0]  sel;
	logic [W_DATA-1:0] expected;
} stim_row_t;

logic                          clk_sys;
logic                          rst_n;
logic                          host_cyc;
logic                          host_stb;
logic                          host_we;
logic [W_ADDR-1:0]             host_adr;
logic [W_SEL-1:0]              host_sel;
logic [W_DATA-1:0]             host_dat_w;
wire  [W_DATA-1:0]             host_dat_r;
wire                           host_ack;
wire  [N_PADS-1:0]             padout;
wire  [N_PADS-1:0]             padoe;
logic [N_PADS-1:0]             padin;
wire                           lcd_pwm;
logic [$clog2(LINE_WORDS)-1:0] scanout_raddr;
wire  [W_DATA-1:0]             scanout_rdata;
wire                           line_done;

stim_row_t         stim_q[$];
logic [W_DATA-1:0] model_mem [MEM_WORDS];
integer            seed;
int                errors;
int                checks;
int                tests_run;
int                tests_failed;
int                errors_at_start;
string             test_name;

riscboy_core i_dut (
	.clk_sys, .rst_n,
	.host_cyc, .host_stb, .host_we, .host_adr, .host_sel, .host_dat_w,
	.host_dat_r, .host_ack,
	.padout, .padoe, .padin, .lcd_pwm,
	.scanout_raddr, .scanout_rdata, .line_done
);

initial clk_sys = 1'b0;
always #10 clk_sys = ~clk_sys;

// ==========================================================================
//  Helpers
// ==========================================================================

task automatic compare_value(input string name, input logic [W_DATA-1:0] got,
		input logic [W_DATA-1:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
		errors++;
	end
endtask

task automatic begin_test(input string name);
	test_name = name;
	errors_at_start = errors;
	tests_run++;
endtask

task automatic finish_test();
	if (errors == errors_at_start) begin
		$display("Test %s: ok", test_name);
	end else begin
		$display("Test %s: failed with %0d errors", test_name, errors - errors_at_start);
		tests_failed++;
	end
endtask

// Word model merges only the byte lanes whose select bit is set
task automatic model_write(input logic [W_ADDR-1:0] addr, input logic [W_DATA-1:0] data,
		input logic [W_SEL-1:0] sel);
	int idx;
	idx = (int'(addr) >> 2) % MEM_WORDS;
	for (int i = 0; i < W_SEL; i++) begin
		if (sel[i]) begin
			model_mem[idx][i*8 +: 8] = data[i*8 +: 8];
		end
	end
endtask

function automatic logic [W_DATA-1:0] model_read(input logic [W_ADDR-1:0] addr);
	return model_mem[(int'(addr) >> 2) % MEM_WORDS];
endfunction

task automatic host_access(input logic we, input logic [W_ADDR-1:0] addr,
		input logic [W_DATA-1:0] data, input logic [W_SEL-1:0] sel,
		output logic [W_DATA-1:0] rdata);
	int n;
	n = 0;
	rdata = '0;
	@(posedge clk_sys);
	host_cyc   <= 1'b1;
	host_stb   <= 1'b1;
	host_we    <= we;
	host_adr   <= addr;
	host_sel   <= sel;
	host_dat_w <= data;
	@(negedge clk_sys);
	while (!host_ack && n < TIMEOUT) begin
		@(negedge clk_sys);
		n++;
	end
	assert (host_ack === 1'b1) else begin
		$display("Timeout: the host access to 0x%04h was never acknowledged", addr);
		errors++;
	end
	if (host_ack === 1'b1) begin
		rdata = host_dat_r;
	end
	@(posedge clk_sys);
	host_cyc <= 1'b0;
	host_stb <= 1'b0;
	host_we  <= 1'b0;
endtask

task automatic add_row(input logic [1:0] tag, input logic [1:0] op,
		input logic [W_ADDR-1:0] addr, input logic [W_DATA-1:0] data,
		input logic [W_SEL-1:0] sel, input logic [W_DATA-1:0] expected);
	stim_row_t r;
	r.tag      = tag;
	r.op       = op;
	r.addr     = addr;
	r.data     = data;
	r.sel      = sel;
	r.expected = expected;
	stim_q.push_back(r);
endtask

task automatic build_table();
	// Partial writes land on top of full words so no lane stays unknown
	add_row(TAG_MEM, OP_WR, 16'h0000, 32'h1122_3344, 4'hf, '0);
	add_row(TAG_MEM, OP_WR, 16'h0000, 32'haabb_ccdd, 4'h5, '0);
	add_row(TAG_MEM, OP_WR, 16'h0004, 32'hcafe_f00d, 4'hf, '0);
	add_row(TAG_MEM, OP_WR, 16'h0004, 32'h0099_0000, 4'h4, '0);
	add_row(TAG_MEM, OP_WR, 16'h0ffc, 32'h1234_5678, 4'hf, '0);
	add_row(TAG_MEM, OP_WR, 16'h0ffc, 32'hffff_ffff, 4'h8, '0);
	add_row(TAG_MEM, OP_RD_MEM, 16'h0000, '0, 4'hf, '0);
	add_row(TAG_MEM, OP_RD_MEM, 16'h0004, '0, 4'hf, '0);
	add_row(TAG_MEM, OP_RD_MEM, 16'h0ffc, '0, 4'hf, '0);
	// One memory depth higher aliases onto the same words
	add_row(TAG_MEM, OP_RD_MEM, 16'h1000, '0, 4'hf, '0);
	add_row(TAG_MEM, OP_RD_MEM, 16'h1004, '0, 4'hf, '0);
	add_row(TAG_MEM, OP_RD_MEM, 16'h1ffc, '0, 4'hf, '0);

	add_row(TAG_GPIO, OP_WR, 16'h8000, 32'hffff_f5a5, 4'hf, '0);
	add_row(TAG_GPIO, OP_WR, 16'h8004, 32'h0000_03c3, 4'hf, '0);
	add_row(TAG_GPIO, OP_RD, 16'h8000, '0, 4'hf, 32'h0000_05a5);
	add_row(TAG_GPIO, OP_RD, 16'h8004, '0, 4'hf, 32'h0000_03c3);

	add_row(TAG_PWM, OP_WR, 16'h9000, 32'h8000_0040, 4'hf, '0);
	add_row(TAG_PWM, OP_RD, 16'h9000, '0, 4'hf, 32'h8000_0040);

	add_row(TAG_NONE, OP_RD, 16'hf000, '0, 4'hf, 32'h0000_0000);
	add_row(TAG_NONE, OP_WR, 16'hf000, 32'hffff_ffff, 4'hf, '0);
	add_row(TAG_NONE, OP_RD, 16'h8000, '0, 4'hf, 32'h0000_05a5);
	add_row(TAG_NONE, OP_RD, 16'h8004, '0, 4'hf, 32'h0000_03c3);
	add_row(TAG_NONE, OP_RD, 16'h9000, '0, 4'hf, 32'h0000_0040);
	add_row(TAG_NONE, OP_RD, 16'ha000, '0, 4'hf, W_DATA'(FETCH_BASE));
	add_row(TAG_NONE, OP_RD, 16'ha004, '0, 4'hf, W_DATA'(LINE_WORDS));
	add_row(TAG_NONE, OP_RD_MEM, 16'h0000, '0, 4'hf, '0);
endtask

task automatic run_rows(input logic [1:0] tag);
	stim_row_t         r;
	logic [W_DATA-1:0] rdata;
	logic [W_DATA-1:0] exp;
	foreach (stim_q[i]) begin
		r = stim_q[i];
		if (r.tag == tag) begin
			host_access(r.op == OP_WR, r.addr, r.data, r.sel, rdata);
			if (r.op == OP_WR) begin
				// Only the lower half of the map is memory
				if (!r.addr[15]) begin
					model_write(r.addr, r.data, r.sel);
				end
			end else begin
				exp = (r.op == OP_RD_MEM) ? model_read(r.addr) : r.expected;
				compare_value("host_dat_r", rdata, exp);
			end
		end
	end
endtask

task automatic count_pwm_high(output int cnt);
	cnt = 0;
	repeat (256) begin
		@(negedge clk_sys);
		if (lcd_pwm === 1'b1) begin
			cnt++;
		end
	end
endtask

// ==========================================================================
//  Tests
// ==========================================================================

task automatic test_gpio_in();
	logic [N_PADS-1:0] pad_val;
	logic [W_DATA-1:0] rdata;
	int                n;
	pad_val = N_PADS'($random(seed));
	@(posedge clk_sys);
	padin <= pad_val;
	n = 0;
	host_access(1'b0, 16'h8008, '0, 4'hf, rdata);
	// The two-flop synchroniser delays the pad value by a couple of cycles
	while (rdata !== W_DATA'(pad_val) && n < 20) begin
		host_access(1'b0, 16'h8008, '0, 4'hf, rdata);
		n++;
	end
	checks++;
	assert (rdata === W_DATA'(pad_val)) else begin
		$display("Timeout: GPIO IN never returned the value driven on padin");
		errors++;
	end
endtask

task automatic test_line_fetch();
	logic [W_DATA-1:0] rdata;
	logic [W_DATA-1:0] wdata;
	logic [W_ADDR-1:0] addr;
	int                n;
	int                during_run;
	for (int i = 0; i < LINE_WORDS; i++) begin
		addr = FETCH_BASE + W_ADDR'(4 * i);
		wdata = $random(seed);
		host_access(1'b1, addr, wdata, 4'hf, rdata);
		model_write(addr, wdata, 4'hf);
	end
	host_access(1'b1, 16'ha000, W_DATA'(FETCH_BASE), 4'hf, rdata);
	host_access(1'b1, 16'ha004, W_DATA'(LINE_WORDS), 4'hf, rdata);
	host_access(1'b1, 16'ha008, 32'h1, 4'hf, rdata);
	host_access(1'b0, 16'ha008, '0, 4'hf, rdata);
	compare_value("host_dat_r (CTRL busy)", rdata, 32'h1);

	during_run = 0;
	for (int k = 0; k < 8; k++) begin
		addr = FETCH_BASE + W_ADDR'(4 * ($random(seed) & (LINE_WORDS - 1)));
		host_access(1'b0, addr, '0, 4'hf, rdata);
		compare_value("host_dat_r", rdata, model_read(addr));
		if (line_done === 1'b0) begin
			during_run++;
		end
	end
	assert (during_run > 0) else begin
		$display("No host read completed while the fetch run was busy");
		errors++;
	end

	n = 0;
	while (line_done !== 1'b1 && n < TIMEOUT) begin
		@(negedge clk_sys);
		n++;
	end
	assert (line_done === 1'b1) else begin
		$display("Timeout: line_done never rose after the fetch run started");
		errors++;
	end
	host_access(1'b0, 16'ha008, '0, 4'hf, rdata);
	compare_value("host_dat_r (CTRL busy)", rdata, 32'h0);

	for (int i = 0; i < LINE_WORDS; i++) begin
		@(posedge clk_sys);
		scanout_raddr <= 6'(i);
		@(posedge clk_sys);
		@(negedge clk_sys);
		compare_value("scanout_rdata", scanout_rdata, model_read(FETCH_BASE + W_ADDR'(4 * i)));
	end
endtask

// ==========================================================================
//  Main sequence
// ==========================================================================

initial begin
	logic [W_DATA-1:0] rdata;
	int                cnt;
	seed          = 32'h843b_9926;
	errors        = 0;
	checks        = 0;
	tests_run     = 0;
	tests_failed  = 0;
	rst_n         = 1'b0;
	host_cyc      = 1'b0;
	host_stb      = 1'b0;
	host_we       = 1'b0;
	host_adr      = '0;
	host_sel      = '0;
	host_dat_w    = '0;
	padin         = '0;
	scanout_raddr = '0;
	build_table();

	repeat (3) @(posedge clk_sys);
	rst_n <= 1'b1;

	begin_test("reset");
	@(negedge clk_sys);
	compare_value("host_ack", W_DATA'(host_ack), '0);
	compare_value("padout", W_DATA'(padout), '0);
	compare_value("padoe", W_DATA'(padoe), '0);
	compare_value("lcd_pwm", W_DATA'(lcd_pwm), '0);
	compare_value("line_done", W_DATA'(line_done), '0);
	finish_test();

	begin_test("memory");
	run_rows(TAG_MEM);
	finish_test();

	begin_test("gpio");
	run_rows(TAG_GPIO);
	compare_value("padout", W_DATA'(padout), 32'h0000_05a5);
	compare_value("padoe", W_DATA'(padoe), 32'h0000_03c3);
	test_gpio_in();
	finish_test();

	begin_test("pwm");
	run_rows(TAG_PWM);
	repeat (4) @(posedge clk_sys);
	count_pwm_high(cnt);
	compare_value("lcd_pwm high count", W_DATA'(cnt), 32'd64);
	host_access(1'b1, 16'h9000, 32'h0000_0040, 4'hf, rdata);
	repeat (2) @(posedge clk_sys);
	count_pwm_high(cnt);
	compare_value("lcd_pwm high count", W_DATA'(cnt), 32'd0);
	finish_test();

	begin_test("line fetch");
	test_line_fetch();
	finish_test();

	begin_test("unmapped");
	run_rows(TAG_NONE);
	finish_test();

	$display("Tests %0d, failed %0d, checks %0d, errors %0d",
		tests_run, tests_failed, checks, errors);
	if (errors == 0) begin
		$display("TB PASSED");
	end else begin
		$display("TB FAILED");
	end
	$finish;
end

endmodule

// File: hdl/riscboy_core.sv
// ==========================================================================
// System slice with host and fetch engine sharing one memory. All acks are
// registered, so each access takes at least two cycles
// ==========================================================================

module riscboy_core import riscboy_pkg::*; #(
	parameter int MEM_WORDS  = 1024,
	parameter int N_PADS     = 11,
	parameter int LINE_WORDS = 64
) (
	input  wire                          clk_sys,
	input  wire                          rst_n,

	input  wire                          host_cyc,
	input  wire                          host_stb,
	input  wire                          host_we,
	input  wire [W_ADDR-1:0]             host_adr,
	input  wire [W_SEL-1:0]              host_sel,
	input  wire [W_DATA-1:0]             host_dat_w,
	output wire [W_DATA-1:0]             host_dat_r,
	output wire                          host_ack,

	output wire [N_PADS-1:0]             padout,
	output wire [N_PADS-1:0]             padoe,
	input  wire [N_PADS-1:0]             padin,
	output wire                          lcd_pwm,

	input  wire [$clog2(LINE_WORDS)-1:0] scanout_raddr,
	output wire [W_DATA-1:0]             scanout_rdata,
	output wire                          line_done
);

wire              fetch_cyc;
wire              fetch_stb;
wire [W_ADDR-1:0] fetch_adr;
wire [W_DATA-1:0] fetch_dat_r;
wire              fetch_ack;

wire              bus_cyc;
wire              bus_stb;
wire              bus_we;
wire [W_ADDR-1:0] bus_adr;
wire [W_SEL-1:0]  bus_sel;
wire [W_DATA-1:0] bus_dat_w;
wire [W_DATA-1:0] bus_dat_r;
wire              bus_ack;

wire              mem_stb;
wire              gpio_stb;
wire              pwm_stb;
wire              line_stb;
wire [W_DATA-1:0] mem_dat_r;
wire [W_DATA-1:0] gpio_dat_r;
wire [W_DATA-1:0] pwm_dat_r;
wire [W_DATA-1:0] line_dat_r;
wire              mem_ack;
wire              gpio_ack;
wire              pwm_ack;
wire              line_ack;

// ==========================================================================
//  Bus fabric
// ==========================================================================

wb_arbiter inst_wb_arbiter (
	.clk_sys, .rst_n,
	.host_cyc, .host_stb, .host_we, .host_adr, .host_sel, .host_dat_w,
	.host_dat_r, .host_ack,
	.fetch_cyc, .fetch_stb, .fetch_adr, .fetch_dat_r, .fetch_ack,
	.bus_cyc, .bus_stb, .bus_we, .bus_adr, .bus_sel, .bus_dat_w,
	.bus_dat_r, .bus_ack
);

wb_decoder inst_wb_decoder (
	.clk_sys, .rst_n,
	.bus_cyc, .bus_stb, .bus_adr, .bus_dat_r, .bus_ack,
	.mem_stb, .gpio_stb, .pwm_stb, .line_stb,
	.mem_dat_r, .gpio_dat_r, .pwm_dat_r, .line_dat_r,
	.mem_ack, .gpio_ack, .pwm_ack, .line_ack
);

// ==========================================================================
//  Slaves
// ==========================================================================

sram_ctrl #(
	.MEM_WORDS (MEM_WORDS)
) inst_sram_ctrl (
	.clk_sys, .rst_n,
	.mem_stb, .bus_we, .bus_adr, .bus_sel, .bus_dat_w,
	.mem_dat_r, .mem_ack
);

gpio #(
	.N_PADS (N_PADS)
) inst_gpio (
	.clk_sys, .rst_n,
	.gpio_stb, .bus_we, .bus_adr, .bus_dat_w,
	.gpio_dat_r, .gpio_ack,
	.padout, .padoe, .padin
);

pwm_tiny inst_pwm_tiny (
	.clk_sys, .rst_n,
	.pwm_stb, .bus_we, .bus_dat_w,
	.pwm_dat_r, .pwm_ack, .lcd_pwm
);

// Register slave and second bus master in one block
line_fetch #(
	.LINE_WORDS (LINE_WORDS)
) inst_line_fetch (
	.clk_sys, .rst_n,
	.line_stb, .bus_we, .bus_adr, .bus_dat_w, .line_dat_r, .line_ack,
	.fetch_cyc, .fetch_stb, .fetch_adr, .fetch_dat_r, .fetch_ack,
	.scanout_raddr, .scanout_rdata, .line_done
);

endmodule

// File: hdl/line_fetch.sv
// ==========================================================================
// Scanline fetch engine. BASE at 0, COUNT at 4 (1 to LINE_WORDS), CTRL at 8
// LINE_WORDS is a power of two of at least 2
// ==========================================================================

module line_fetch import riscboy_pkg::*; #(
	parameter int LINE_WORDS = 64
) (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire                          line_stb,
	input  wire                          bus_we,
	input  wire [W_ADDR-1:0]             bus_adr,
	input  wire [W_DATA-1:0]             bus_dat_w,
	output logic [W_DATA-1:0]            line_dat_r,
	output logic                         line_ack,

	output logic                         fetch_cyc,
	output wire                          fetch_stb,
	output wire [W_ADDR-1:0]             fetch_adr,
	input  wire [W_DATA-1:0]             fetch_dat_r,
	input  wire                          fetch_ack,

	input  wire [$clog2(LINE_WORDS)-1:0] scanout_raddr,
	output logic [W_DATA-1:0]            scanout_rdata,
	output logic                         line_done
);

localparam int W_IDX = $clog2(LINE_WORDS);

fetch_state_e      state;
logic [W_ADDR-1:0] base_q;
logic [W_IDX:0]    count_q;
logic [W_IDX:0]    idx_q;
logic [W_DATA-1:0] line_buf [LINE_WORDS];

wire access = line_stb && !line_ack;
wire start  = access && bus_we && bus_adr[3:2] == 2'd2 && bus_dat_w[0] && state == FETCH_IDLE;
wire last   = idx_q + 1'b1 >= count_q;

assign fetch_stb = fetch_cyc;
assign fetch_adr = base_q + (W_ADDR'(idx_q) << 2);

always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		state     <= FETCH_IDLE;
		fetch_cyc <= 1'b0;
		line_done <= 1'b0;
		line_ack  <= 1'b0;
		base_q    <= '0;
		count_q   <= '0;
		idx_q     <= '0;
	end else begin
		line_ack <= access;
		if (access && bus_we) begin
			case (bus_adr[3:2])
				2'd0:    base_q <= bus_dat_w[W_ADDR-1:0];
				2'd1:    count_q <= bus_dat_w[W_IDX:0];
				default: ;
			endcase
		end
		case (state)
			FETCH_IDLE: if (start) begin
				state     <= FETCH_RUN;
				idx_q     <= '0;
				fetch_cyc <= 1'b1;
				line_done <= 1'b0;
			end
			// Drop cyc for one cycle between words so the host can get in
			FETCH_RUN: if (!fetch_cyc) begin
				fetch_cyc <= 1'b1;
			end else if (fetch_ack) begin
				fetch_cyc <= 1'b0;
				idx_q     <= idx_q + 1'b1;
				if (last) begin
					state     <= FETCH_IDLE;
					line_done <= 1'b1;
				end
			end
			default: state <= FETCH_IDLE;
		endcase
	end
end

always_ff @(posedge clk_sys) begin
	if (fetch_cyc && fetch_ack) begin
		line_buf[idx_q[W_IDX-1:0]] <= fetch_dat_r;
	end
	scanout_rdata <= line_buf[scanout_raddr];
	if (access) begin
		case (bus_adr[3:2])
			2'd0:    line_dat_r <= W_DATA'(base_q);
			2'd1:    line_dat_r <= W_DATA'(count_q);
			2'd2:    line_dat_r <= W_DATA'(state == FETCH_RUN);
			default: line_dat_r <= '0;
		endcase
	end
end

endmodule

// File: hdl/pwm_tiny.sv
// ==========================================================================
// Backlight PWM with a 256-cycle period. One register at every offset
// ==========================================================================

module pwm_tiny import riscboy_pkg::*; (
	input  wire              clk_sys,
	input  wire              rst_n,
	input  wire              pwm_stb,
	input  wire              bus_we,
	input  wire [W_DATA-1:0] bus_dat_w,
	output wire [W_DATA-1:0] pwm_dat_r,
	output logic             pwm_ack,
	output logic             lcd_pwm
);

logic [7:0] ctr;
logic [7:0] level;
logic       en;

wire access = pwm_stb && !pwm_ack;

always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		pwm_ack <= 1'b0;
		ctr     <= 8'h0;
		level   <= 8'h0;
		en      <= 1'b0;
		lcd_pwm <= 1'b0;
	end else begin
		pwm_ack <= access;
		ctr     <= ctr + 8'h1;
		if (access && bus_we) begin
			level <= bus_dat_w[7:0];
			en    <= bus_dat_w[31];
		end
		// Duty is level/256, so a level of zero keeps the output low
		lcd_pwm <= en && ctr < level;
	end
end

// Bit 31 enable, bits 7:0 level
assign pwm_dat_r = {en, {(W_DATA - 9){1'b0}}, level};

endmodule

// File: hdl/gpio.sv
// ==========================================================================
// GPIO with OUT at 0, OE at 4 and read-only IN at 8. N_PADS is below 32
// ==========================================================================

module gpio import riscboy_pkg::*; #(
	parameter int N_PADS = 11
) (
	input  wire               clk_sys,
	input  wire               rst_n,
	input  wire               gpio_stb,
	input  wire               bus_we,
	input  wire [W_ADDR-1:0]  bus_adr,
	input  wire [W_DATA-1:0]  bus_dat_w,
	output logic [W_DATA-1:0] gpio_dat_r,
	output logic              gpio_ack,
	output logic [N_PADS-1:0] padout,
	output logic [N_PADS-1:0] padoe,
	input  wire  [N_PADS-1:0] padin
);

logic [N_PADS-1:0] in_meta;
logic [N_PADS-1:0] in_sync;

wire access = gpio_stb && !gpio_ack;

always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		gpio_ack <= 1'b0;
		padout   <= '0;
		padoe    <= '0;
		in_meta  <= '0;
		in_sync  <= '0;
	end else begin
		gpio_ack <= access;
		// Pad inputs are asynchronous to clk_sys
		in_meta  <= padin;
		in_sync  <= in_meta;
		if (access && bus_we) begin
			case (bus_adr[3:2])
				2'd0:    padout <= bus_dat_w[N_PADS-1:0];
				2'd1:    padoe <= bus_dat_w[N_PADS-1:0];
				default: ;
			endcase
		end
	end
end

always_ff @(posedge clk_sys) begin
	if (access) begin
		case (bus_adr[3:2])
			2'd0:    gpio_dat_r <= W_DATA'(padout);
			2'd1:    gpio_dat_r <= W_DATA'(padoe);
			2'd2:    gpio_dat_r <= W_DATA'(in_sync);
			default: gpio_dat_r <= '0;
		endcase
	end
end

endmodule

// File: hdl/sram_ctrl.sv
// ==========================================================================
// Synchronous word memory. MEM_WORDS must be a power of two up to 8192 and
// addresses wrap modulo the depth. Contents are undefined after power-up
// ==========================================================================

module sram_ctrl import riscboy_pkg::*; #(
	parameter int MEM_WORDS = 1024
) (
	input  wire               clk_sys,
	input  wire               rst_n,
	input  wire               mem_stb,
	input  wire               bus_we,
	input  wire [W_ADDR-1:0]  bus_adr,
	input  wire [W_SEL-1:0]   bus_sel,
	input  wire [W_DATA-1:0]  bus_dat_w,
	output logic [W_DATA-1:0] mem_dat_r,
	output logic              mem_ack
);

localparam int W_IDX = $clog2(MEM_WORDS);

logic [W_DATA-1:0] mem [MEM_WORDS];

wire [W_IDX-1:0] idx = bus_adr[W_IDX+1:2];
// First cycle of a strobe, so each access touches the array once
wire access = mem_stb && !mem_ack;

always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		mem_ack <= 1'b0;
	end else begin
		mem_ack <= access;
	end
end

always_ff @(posedge clk_sys) begin
	if (access) begin
		if (bus_we) begin
			for (int i = 0; i < W_SEL; i++) begin
				if (bus_sel[i]) begin
					mem[idx][i*8 +: 8] <= bus_dat_w[i*8 +: 8];
				end
			end
		end
		mem_dat_r <= mem[idx];
	end
end

endmodule

// File: hdl/wb_decoder.sv
// ==========================================================================
// Address decoder on bits 15:12. Unmapped accesses get a one-cycle ack
// with zero read data and writes there are dropped
// ==========================================================================

module wb_decoder import riscboy_pkg::*; (
	input  wire              clk_sys,
	input  wire              rst_n,
	input  wire              bus_cyc,
	input  wire              bus_stb,
	input  wire [W_ADDR-1:0] bus_adr,
	output logic [W_DATA-1:0] bus_dat_r,
	output logic             bus_ack,

	output wire              mem_stb,
	output wire              gpio_stb,
	output wire              pwm_stb,
	output wire              line_stb,
	input  wire [W_DATA-1:0] mem_dat_r,
	input  wire [W_DATA-1:0] gpio_dat_r,
	input  wire [W_DATA-1:0] pwm_dat_r,
	input  wire [W_DATA-1:0] line_dat_r,
	input  wire              mem_ack,
	input  wire              gpio_ack,
	input  wire              pwm_ack,
	input  wire              line_ack
);

slot_e slot;
logic  none_ack;

always_comb begin
	case (bus_adr[W_ADDR-1 -: 4])
		4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: slot = SLOT_MEM;
		4'h8:    slot = SLOT_GPIO;
		4'h9:    slot = SLOT_PWM;
		4'ha:    slot = SLOT_LINE;
		default: slot = SLOT_NONE;
	endcase
end

wire req = bus_cyc && bus_stb;

assign mem_stb  = req && slot == SLOT_MEM;
assign gpio_stb = req && slot == SLOT_GPIO;
assign pwm_stb  = req && slot == SLOT_PWM;
assign line_stb = req && slot == SLOT_LINE;

// Stand-in slave for holes in the map
always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		none_ack <= 1'b0;
	end else begin
		none_ack <= req && slot == SLOT_NONE && !none_ack;
	end
end

always_comb begin
	case (slot)
		SLOT_MEM:  {bus_ack, bus_dat_r} = {mem_ack, mem_dat_r};
		SLOT_GPIO: {bus_ack, bus_dat_r} = {gpio_ack, gpio_dat_r};
		SLOT_PWM:  {bus_ack, bus_dat_r} = {pwm_ack, pwm_dat_r};
		SLOT_LINE: {bus_ack, bus_dat_r} = {line_ack, line_dat_r};
		default:   {bus_ack, bus_dat_r} = {none_ack, {W_DATA{1'b0}}};
	endcase
end

endmodule

// File: hdl/wb_arbiter.sv
// ==========================================================================
// Two-master Wishbone arbiter. The grant only moves while the owner's cyc
// is low, so a master that never drops cyc starves the other one
// ==========================================================================

module wb_arbiter import riscboy_pkg::*; (
	input  wire              clk_sys,
	input  wire              rst_n,

	input  wire              host_cyc,
	input  wire              host_stb,
	input  wire              host_we,
	input  wire [W_ADDR-1:0] host_adr,
	input  wire [W_SEL-1:0]  host_sel,
	input  wire [W_DATA-1:0] host_dat_w,
	output wire [W_DATA-1:0] host_dat_r,
	output wire              host_ack,

	input  wire              fetch_cyc,
	input  wire              fetch_stb,
	input  wire [W_ADDR-1:0] fetch_adr,
	output wire [W_DATA-1:0] fetch_dat_r,
	output wire              fetch_ack,

	output wire              bus_cyc,
	output wire              bus_stb,
	output wire              bus_we,
	output wire [W_ADDR-1:0] bus_adr,
	output wire [W_SEL-1:0]  bus_sel,
	output wire [W_DATA-1:0] bus_dat_w,
	input  wire [W_DATA-1:0] bus_dat_r,
	input  wire              bus_ack
);

logic owner_fetch;
logic grant_fetch;

// Keep the current owner mid-cycle, otherwise the fetch engine wins a tie
always_comb begin
	if (owner_fetch ? fetch_cyc : host_cyc) begin
		grant_fetch = owner_fetch;
	end else if (fetch_cyc) begin
		grant_fetch = 1'b1;
	end else if (host_cyc) begin
		grant_fetch = 1'b0;
	end else begin
		grant_fetch = owner_fetch;
	end
end

always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		owner_fetch <= 1'b0;
	end else begin
		owner_fetch <= grant_fetch;
	end
end

assign bus_cyc   = grant_fetch ? fetch_cyc : host_cyc;
assign bus_stb   = grant_fetch ? fetch_stb : host_stb;
// The fetch engine is read-only and always takes the full word
assign bus_we    = grant_fetch ? 1'b0 : host_we;
assign bus_adr   = grant_fetch ? fetch_adr : host_adr;
assign bus_sel   = grant_fetch ? {W_SEL{1'b1}} : host_sel;
assign bus_dat_w = host_dat_w;

assign host_dat_r  = bus_dat_r;
assign fetch_dat_r = bus_dat_r;
assign host_ack    = bus_ack && !grant_fetch;
assign fetch_ack   = bus_ack && grant_fetch;

endmodule

// File: hdl/riscboy_pkg.sv
// ==========================================================================
// Bus widths and enums shared by every block. The address map decodes bits
// 15:12 only, so the 64 KiB byte space is the whole system view
// ==========================================================================

package riscboy_pkg;

localparam int W_ADDR = 16;
localparam int W_DATA = 32;
localparam int W_SEL  = 4;

// Decoder target for one access
typedef enum logic [2:0] {
	SLOT_MEM,
	SLOT_GPIO,
	SLOT_PWM,
	SLOT_LINE,
	SLOT_NONE
} slot_e;

// Fetch engine sequencing
typedef enum logic {
	FETCH_IDLE,
	FETCH_RUN
} fetch_state_e;

endpackage
